//--- dv/tb_pdm_model.svh
`ifndef TB_PDM_MODEL_SVH
`define TB_PDM_MODEL_SVH

    localparam int   CHANNELS = 6;
    localparam pdm_t PDM_MAX  = '1;

    pdm_t err_model  [`LED_ROWS][`LED_COLS][CHANNELS];   // error per pixel and channel
    int   ones_seen  [`LED_ROWS][`LED_COLS][CHANNELS];   // counted from the panel pins

    // same starting point as the DUT after ext_reset
    function automatic void clear_model();
        for (int r = 0; r < `LED_ROWS; r++) begin
            for (int c = 0; c < `LED_COLS; c++) begin
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    err_model[r][c][ch]  = '0;
                    ones_seen[r][c][ch]  = 0;
                end
            end
        end
    endfunction

    // channels 0..2 are b, g, r of the top half, 3..5 the bottom half
    function automatic level_t channel_level(input rgb24_t top, input rgb24_t bottom,
                                             input int ch);
        rgb24_t c;
        c = (ch < 3) ? top : bottom;
        case (ch % 3)
            0:       return c.b;
            1:       return c.g;
            default: return c.r;
        endcase
    endfunction

    // low 9 bits of {level, 2'b10}
    function automatic pdm_t pdm_target(input level_t lvl);
        return {1'b0, lvl[`LEVEL_BITS-2:0], 2'b10};
    endfunction

    // error from zero steps down by the target modulo PDM_MAX, one bit per wrap
    function automatic int expected_ones(input level_t lvl, input int steps);
        int total;
        total = steps * int'(pdm_target(lvl));
        return (total + int'(PDM_MAX) - 1) / int'(PDM_MAX);
    endfunction

    // one pdm step for all six channels of a pixel pair
    function automatic pix_bits_t model_pixel(input row_t row, input col_t col,
                                              input rgb24_t top, input rgb24_t bottom);
        pix_bits_t          exp_bits;
        logic [CHANNELS-1:0] ch_bits;
        pdm_t               target;
        pdm_t               err;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            target = pdm_target(channel_level(top, bottom, ch));
            err    = err_model[row][col][ch];
            if (target > err) begin
                ch_bits[ch] = 1'b1;
                err         = PDM_MAX - (target - err);
            end else begin
                ch_bits[ch] = 1'b0;
                err         = err - target;
            end
            err_model[row][col][ch] = err;
        end
        exp_bits.rgb0 = ch_bits[2:0];   // r in bit 2, b in bit 0
        exp_bits.rgb1 = ch_bits[5:3];
        return exp_bits;
    endfunction

    function automatic void count_seen(input row_t row, input col_t col, input pix_bits_t got);
        for (int ch = 0; ch < 3; ch++) begin
            ones_seen[row][col][ch]     += int'(got.rgb0[ch]);
            ones_seen[row][col][ch + 3] += int'(got.rgb1[ch]);
        end
    endfunction

    task automatic check_bits(input pix_bits_t got, input pix_bits_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: bits %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_row(input row_t got, input row_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: addr %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: pin is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s: %0d ones, expected %0d", what, got, exp));
        end
    endtask

`endif

//--- dv/tb_led_panel.sv
`include "led_defs.svh"

module tb_led_panel;
    import led_pkg::*;

    localparam int SCLK_WAIT  = 16;   // cycles allowed between sclk pulses
    localparam int LATCH_WAIT = 8;
    localparam int ENTRIES    = 6;

    typedef struct packed {
        rgb24_t top;
        rgb24_t bottom;
        int     subframes;
    } stim_t;

    logic        clk;
    logic        ext_reset;
    rgb24_t      color_top;
    rgb24_t      color_bottom;
    panel_pins_t led_panel;

    int    errors;
    logic  last_sclk;   // sclk at the previous sample
    stim_t stim_table [ENTRIES];

    led_panel_top u_dut (
        .clk          (clk),
        .ext_reset    (ext_reset),
        .color_top    (color_top),
        .color_bottom (color_bottom),
        .led_panel    (led_panel)
    );

    always #50 clk = ~clk;

    task automatic end_run_failed();
        $display("Test failed");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail at time %0t: %s", $time, msg);
        end_run_failed();
    endtask

    task automatic report_timeout(input string msg);
        errors++;
        $display("Timeout at time %0t: %s", $time, msg);
        end_run_failed();
    endtask

    `include "tb_pdm_model.svh"

    // pins are sampled mid cycle, away from the rising edge
    task automatic sample_pins();
        @(negedge clk);
        if (led_panel.sclk && last_sclk) begin
            report_mismatch("sclk stayed high for two cycles in a row");
        end
        last_sclk = led_panel.sclk;
    endtask

    task automatic wait_sclk(input bit first_row);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < SCLK_WAIT) begin
            sample_pins();
            n++;
            check_flag(led_panel.latch, 1'b0, "latch while shifting");
            if (first_row) begin
                check_flag(led_panel.blank, 1'b1, "blank before the first latch");
                check_row(led_panel.addr, '0, "addr before the first latch");
            end
            seen = led_panel.sclk;
        end
        if (!seen) begin
            report_timeout("no sclk pulse arrived within the wait limit");
        end
    endtask

    task automatic wait_latch();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < LATCH_WAIT) begin
            sample_pins();
            n++;
            check_flag(led_panel.sclk, 1'b0, "sclk after the 64th bit");
            seen = led_panel.latch;
        end
        if (!seen) begin
            report_timeout("no latch pulse arrived after the 64th sclk");
        end
    endtask

    task automatic shift_row(input row_t row, input bit first_row);
        pix_bits_t got;
        pix_bits_t exp;
        for (int c = 0; c < `LED_COLS; c++) begin
            wait_sclk(first_row);
            got.rgb0 = led_panel.rgb0;
            got.rgb1 = led_panel.rgb1;
            exp      = model_pixel(row, col_t'(c), color_top, color_bottom);
            check_bits(got, exp, $sformatf("row %0d col %0d", row, c));
            count_seen(row, col_t'(c), got);
        end
        wait_latch();
        check_flag(led_panel.blank, 1'b1, "blank during latch");
        sample_pins();
        check_flag(led_panel.latch, 1'b0, "latch one cycle wide");
        check_flag(led_panel.blank, 1'b0, "blank after latch");
        check_row(led_panel.addr, row, "addr after latch");
    endtask

    task automatic compare_counts(input stim_t e);
        int exp_ones;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            exp_ones = expected_ones(channel_level(e.top, e.bottom, ch), e.subframes);
            for (int r = 0; r < `LED_ROWS; r++) begin
                for (int c = 0; c < `LED_COLS; c++) begin
                    check_count(ones_seen[r][c][ch], exp_ones,
                                $sformatf("row %0d col %0d channel %0d", r, c, ch));
                end
            end
        end
    endtask

    task automatic run_entry(input stim_t e);
        pix_bits_t rgb_pins;
        @(negedge clk);
        ext_reset    = 1'b0;
        color_top    = e.top;
        color_bottom = e.bottom;
        last_sclk    = 1'b0;
        clear_model();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            rgb_pins.rgb0 = led_panel.rgb0;
            rgb_pins.rgb1 = led_panel.rgb1;
            check_flag(led_panel.blank, 1'b1, "blank in reset");
            check_flag(led_panel.latch, 1'b0, "latch in reset");
            check_flag(led_panel.sclk, 1'b0, "sclk in reset");
            check_row(led_panel.addr, '0, "addr in reset");
            check_bits(rgb_pins, '0, "rgb in reset");
        end
        ext_reset = 1'b1;
        for (int sf = 0; sf < e.subframes; sf++) begin
            for (int r = 0; r < `LED_ROWS; r++) begin
                shift_row(row_t'(r), sf == 0 && r == 0);
            end
        end
        compare_counts(e);
    endtask

    initial begin
        int          seed_ret;
        logic [31:0] rnd;
        clk          = 1'b0;
        ext_reset    = 1'b0;
        color_top    = '0;
        color_bottom = '0;
        errors       = 0;
        last_sclk    = 1'b0;
        seed_ret     = $urandom(32'h0da9_4302);

        stim_table[0] = '{top: '0, bottom: '0, subframes: 2};   // black, target is still 2
        stim_table[1] = '{top: '1, bottom: '1, subframes: 3};   // full level
        stim_table[2] = '{top: 24'h80_40_ff, bottom: 24'h01_c3_7f, subframes: 3};
        for (int i = 3; i < ENTRIES; i++) begin
            rnd                     = $urandom();
            stim_table[i].top       = rnd[23:0];
            rnd                     = $urandom();
            stim_table[i].bottom    = rnd[23:0];
            stim_table[i].subframes = 3;
        end

        for (int i = 0; i < ENTRIES; i++) begin
            run_entry(stim_table[i]);
        end

        if (errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            end_run_failed();
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_led_panel -o sim_tb &&
./obj_dir/sim_tb || exit 1

//--- tb.f
+incdir+verilog
+incdir+dv
verilog/led_pkg.sv
verilog/scan_counter.sv
verilog/error_ram.sv
verilog/pdm_stage.sv
verilog/row_driver.sv
verilog/led_panel_top.sv
dv/tb_led_panel.sv

//--- verilog/error_ram.sv
module error_ram #(
    parameter int DEPTH = 1 << $bits(led_pkg::pixel_pos_t),
    parameter int WIDTH = $bits(led_pkg::pix_err_t)
) (
    input  logic                clk,
    input  led_pkg::pixel_pos_t rd_addr,
    output led_pkg::pix_err_t   rd_data,
    input  logic                wr_en,
    input  led_pkg::pixel_pos_t wr_addr,
    input  led_pkg::pix_err_t   wr_data
);
    import led_pkg::*;

    logic [WIDTH-1:0] mem [DEPTH];   // one word per pixel pair

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= WIDTH'(wr_data);
        end
        rd_data <= pix_err_t'(mem[rd_addr]);   // data one cycle after address
    end

endmodule

//--- verilog/led_defs.svh
`ifndef LED_DEFS_SVH
`define LED_DEFS_SVH

// panel geometry
`define LED_COLS 64
`define LED_ROWS 32
`define LED_PIXELS (`LED_COLS * `LED_ROWS)

// idle cycles after the last column slot of a row
`define ROW_GAP 3

// channel widths
`define LEVEL_BITS 8
`define PDM_BITS 10

`endif

//--- verilog/led_panel_top.sv
module led_panel_top (
    input  logic                 clk,
    input  logic                 ext_reset,
    input  led_pkg::rgb24_t      color_top,
    input  led_pkg::rgb24_t      color_bottom,
    output led_pkg::panel_pins_t led_panel
);
    import led_pkg::*;

    logic       pixel_valid;
    pixel_pos_t pos;
    logic       bits_valid;
    pix_bits_t  bits;
    pixel_pos_t bits_pos;

    // one pixel pair per two-cycle column slot
    scan_counter u_scan (
        .clk         (clk),
        .ext_reset   (ext_reset),
        .pixel_valid (pixel_valid),
        .pos         (pos)
    );

    pdm_stage u_pdm (
        .clk          (clk),
        .ext_reset    (ext_reset),
        .pixel_valid  (pixel_valid),
        .pos          (pos),
        .color_top    (color_top),
        .color_bottom (color_bottom),
        .bits_valid   (bits_valid),
        .bits         (bits),
        .bits_pos     (bits_pos)
    );

    row_driver u_drv (
        .clk        (clk),
        .ext_reset  (ext_reset),
        .bits_valid (bits_valid),
        .bits       (bits),
        .bits_pos   (bits_pos),
        .led_panel  (led_panel)
    );

endmodule

//--- verilog/led_pkg.sv
`include "led_defs.svh"

package led_pkg;

    typedef logic [$clog2(`LED_ROWS)-1:0] row_t;    // row pair index
    typedef logic [$clog2(`LED_COLS)-1:0] col_t;
    typedef logic [`LEVEL_BITS-1:0]       level_t;
    typedef logic [`PDM_BITS-1:0]         pdm_t;    // pdm value or error value

    typedef struct packed {
        level_t r;
        level_t g;
        level_t b;
    } rgb24_t;

    // also the error memory address
    typedef struct packed {
        row_t row;
        col_t col;
    } pixel_pos_t;

    // index is half * 3 + channel, channel 0 is blue
    typedef pdm_t [5:0] pix_err_t;

    typedef struct packed {
        logic [2:0] rgb0;    // top half
        logic [2:0] rgb1;    // bottom half
    } pix_bits_t;

    typedef struct packed {
        logic [2:0] rgb0;
        logic [2:0] rgb1;
        row_t       addr;
        logic       blank;
        logic       latch;
        logic       sclk;
    } panel_pins_t;

    typedef enum logic [1:0] {
        s_start,
        s_shift,
        s_blank,
        s_unblank
    } drv_state_t;

endpackage

//--- verilog/pdm_stage.sv
`include "led_defs.svh"

module pdm_stage (
    input  logic                clk,
    input  logic                ext_reset,
    input  logic                pixel_valid,
    input  led_pkg::pixel_pos_t pos,
    input  led_pkg::rgb24_t     color_top,
    input  led_pkg::rgb24_t     color_bottom,
    output logic                bits_valid,
    output led_pkg::pix_bits_t  bits,
    output led_pkg::pixel_pos_t bits_pos
);
    import led_pkg::*;

    localparam int CHANNELS = 6;
    localparam pixel_pos_t LAST_POS = '{
        row: row_t'(`LED_ROWS - 1),
        col: col_t'(`LED_COLS - 1)
    };

    logic                            valid_d;
    pixel_pos_t                      pos_d;
    logic                            clear_pass;   // first subframe after reset
    pix_err_t                        err_rd;
    pix_err_t                        err_in;
    pix_err_t                        err_new;
    logic [CHANNELS-1:0]             bit_new;
    logic [CHANNELS*`LEVEL_BITS-1:0] levels;

    error_ram #(
        .DEPTH (`LED_PIXELS),
        .WIDTH ($bits(pix_err_t))
    ) u_error_ram (
        .clk     (clk),
        .rd_addr (pos),
        .rd_data (err_rd),
        .wr_en   (valid_d),
        .wr_addr (pos_d),
        .wr_data (err_new)
    );

    assign levels = {color_bottom, color_top};   // top half in the low channels

    // the clear sweep rides along with the first subframe: each word is read as
    // zero and overwritten, so every pixel starts from a zero error
    assign err_in = clear_pass ? '0 : err_rd;

    always_comb begin : calc
        pdm_t expanded;
        pdm_t target;
        for (int i = 0; i < CHANNELS; i++) begin
            expanded = {levels[i*`LEVEL_BITS +: `LEVEL_BITS], 2'b10};
            target   = {1'b0, expanded[`PDM_BITS-2:0]};   // low 9 bits only
            if (target > err_in[i]) begin
                bit_new[i] = 1'b1;
                err_new[i] = '1 - (target - err_in[i]);
            end else begin
                bit_new[i] = 1'b0;
                err_new[i] = err_in[i] - target;
            end
        end
    end

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            valid_d    <= 1'b0;
            bits_valid <= 1'b0;
            clear_pass <= 1'b1;
        end else begin
            valid_d    <= pixel_valid;   // meets the read data
            bits_valid <= valid_d;
            if (valid_d && pos_d == LAST_POS) begin
                clear_pass <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        pos_d <= pos;
        if (valid_d) begin
            bits.rgb0 <= bit_new[2:0];
            bits.rgb1 <= bit_new[5:3];
            bits_pos  <= pos_d;
        end
    end

endmodule

//--- verilog/row_driver.sv
`include "led_defs.svh"

module row_driver (
    input  logic                 clk,
    input  logic                 ext_reset,
    input  logic                 bits_valid,
    input  led_pkg::pix_bits_t   bits,
    input  led_pkg::pixel_pos_t  bits_pos,
    output led_pkg::panel_pins_t led_panel
);
    import led_pkg::*;

    drv_state_t state;
    logic       sclk_pend;   // data is on the pins, clock it next
    logic       last_pend;   // pending bit is the last of the row
    row_t       row_q;       // row being shifted

    always_ff @(posedge clk) begin
        if (bits_valid) begin
            row_q <= bits_pos.row;
        end
    end

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            led_panel <= '{blank: 1'b1, default: '0};
            state     <= s_start;
            sclk_pend <= 1'b0;
            last_pend <= 1'b0;
        end else begin
            led_panel.sclk <= sclk_pend;   // one cycle pulse, data already stable
            sclk_pend      <= 1'b0;
            case (state)
                s_start, s_shift: begin
                    if (bits_valid) begin
                        led_panel.rgb0 <= bits.rgb0;
                        led_panel.rgb1 <= bits.rgb1;
                        sclk_pend      <= 1'b1;
                        last_pend      <= (bits_pos.col == col_t'(`LED_COLS - 1));
                        state          <= s_shift;
                    end
                    if (sclk_pend && last_pend) begin
                        last_pend <= 1'b0;
                        state     <= s_blank;   // 64th bit clocked now
                    end
                end
                s_blank: begin
                    led_panel.blank <= 1'b1;
                    led_panel.latch <= 1'b1;
                    state           <= s_unblank;
                end
                s_unblank: begin
                    led_panel.latch <= 1'b0;
                    led_panel.blank <= 1'b0;
                    led_panel.addr  <= row_q;   // show the row just latched
                    state           <= s_shift;
                end
                default: begin
                    state <= s_start;
                end
            endcase
        end
    end

endmodule

//--- verilog/scan_counter.sv
`include "led_defs.svh"

module scan_counter (
    input  logic                clk,
    input  logic                ext_reset,
    output logic                pixel_valid,
    output led_pkg::pixel_pos_t pos
);
    import led_pkg::*;

    localparam int GAP_W = $clog2(`ROW_GAP + 1);

    logic             phase;      // second cycle of a column slot
    logic             in_gap;     // idle cycles after the row
    logic [GAP_W-1:0] gap_cnt;
    col_t             col;
    row_t             row;

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            phase   <= 1'b0;
            in_gap  <= 1'b0;
            gap_cnt <= '0;
            col     <= '0;
            row     <= '0;
        end else if (in_gap) begin
            if (gap_cnt == GAP_W'(`ROW_GAP - 1)) begin
                in_gap  <= 1'b0;
                gap_cnt <= '0;
                // wrap ends the subframe
                if (row == row_t'(`LED_ROWS - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end else begin
            phase <= ~phase;
            if (phase) begin
                if (col == col_t'(`LED_COLS - 1)) begin
                    col    <= '0;
                    in_gap <= 1'b1;   // last slot done
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    assign pixel_valid = ~phase & ~in_gap;   // first cycle of each slot
    assign pos         = '{row: row, col: col};

endmodule
